/* fetch_pkg.sv */
// Instruction fetch package
// Bus constants, default widths and the sizing helper shared by the
// AXI-lite instruction fetch unit
package fetch_pkg;

	////////////////////////////////////////////////////////////
	// Default widths
	////////////////////////////////////////////////////////////

	// Bus address and data
	localparam int DEFAULT_ADDR_WIDTH = 32;
	localparam int DEFAULT_DATA_WIDTH = 64;

	// One CPU instruction
	localparam int DEFAULT_INSN_WIDTH = 32;

	// Words requested ahead of the CPU, power of two, 4 or more
	localparam int DEFAULT_FETCH_LIMIT = 16;

	////////////////////////////////////////////////////////////
	// Bus constants
	////////////////////////////////////////////////////////////

	// Unprivileged, secure, instruction access
	localparam logic [2:0] ARPROT_INSN = 3'b100;

	// SLVERR and DECERR both set this bit of RRESP
	localparam int RESP_ERR_BIT = 1;

	////////////////////////////////////////////////////////////
	// Sizing helpers
	////////////////////////////////////////////////////////////

	// Outstanding read counter width
	// Leaves generous headroom above the cache depth
	function automatic int outstanding_bits(input int fetch_limit);
		return $clog2(fetch_limit) + 4;
	endfunction

endpackage

/* fetch_request_ctrl.sv */
// Fetch request controller
// Issues AXI-lite read-address requests, follows CPU redirects and
// throttles the stream against the cache fill and the bus ceiling
module fetch_request_ctrl #(
	parameter int ADDR_WIDTH  = fetch_pkg::DEFAULT_ADDR_WIDTH,
	parameter int DATA_WIDTH  = fetch_pkg::DEFAULT_DATA_WIDTH,
	parameter int FETCH_LIMIT = fetch_pkg::DEFAULT_FETCH_LIMIT
) (
	input  logic                  S_AXI_ACLK,
	input  logic                  S_AXI_ARESETN,
	input  logic                  i_cpu_reset,
	input  logic                  i_new_pc,
	input  logic                  i_clear_cache,
	input  logic [ADDR_WIDTH-1:0] i_pc,
	input  logic                  i_arready,
	input  logic                  i_word_taken,
	input  logic                  i_held_words,
	input  logic                  i_bus_full,
	output logic                  o_arvalid,
	output logic [ADDR_WIDTH-1:0] o_araddr,
	output logic                  o_restart,
	output logic                  o_flush_request
);

	// Byte offset bits within one bus word
	localparam int WORD_LSB = $clog2(DATA_WIDTH/8);
	// Fill must reach FETCH_LIMIT itself
	localparam int FILL_W = $clog2(FETCH_LIMIT) + 1;
	localparam int SUM_W = FILL_W + 1;

	logic                  pending_new_pc;
	logic [ADDR_WIDTH-1:0] pending_pc;
	logic [FILL_W-1:0]     fill;
	logic [SUM_W-1:0]      fill_sum;
	logic                  addr_free;

	// Reset counts as a restart so every downstream block clears
	assign o_restart = !S_AXI_ARESETN || i_cpu_reset || i_clear_cache || i_new_pc;

	// Address register may change
	assign addr_free = !o_arvalid || i_arready;

	////////////////////////////////////////////////////////////
	// Throttle
	////////////////////////////////////////////////////////////

	// Requested, waiting and held words
	assign fill_sum = {1'b0, fill} + SUM_W'(o_arvalid) + SUM_W'(i_held_words);

	// Words requested minus words popped by the unpacker
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_restart)
			fill <= '0;
		else
			case ({o_arvalid && i_arready && !o_flush_request, i_word_taken})
			2'b10: fill <= fill + 1'b1;
			2'b01: fill <= fill - 1'b1;
			default: ;
			endcase
	end

	////////////////////////////////////////////////////////////
	// Address channel
	////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_arvalid <= 1'b0;
		else if (addr_free)
		begin
			o_arvalid <= 1'b1;
			// Stale fill is ignored on a redirect
			if (!i_new_pc && fill_sum >= FETCH_LIMIT)
				o_arvalid <= 1'b0;
			if (i_cpu_reset || i_clear_cache || i_bus_full)
				o_arvalid <= 1'b0;
		end
	end

	// New pc, then pending pc, then next aligned word
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (addr_free)
		begin
			if (i_new_pc)
				o_araddr <= i_pc;
			else if (pending_new_pc)
				o_araddr <= pending_pc;
			else if (o_arvalid)
				o_araddr <= ((o_araddr >> WORD_LSB) + 1'b1) << WORD_LSB;
		end
	end

	// Redirect that arrived while a request was stalled
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_clear_cache || addr_free)
			pending_new_pc <= 1'b0;
		else if (i_new_pc)
			pending_new_pc <= 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_new_pc)
			pending_pc <= i_pc;
	end

	// Stalled request at restart, its response is stale
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_flush_request <= 1'b0;
		else if (o_restart)
			o_flush_request <= o_arvalid && !i_arready;
		else if (i_arready)
			o_flush_request <= 1'b0;
	end

endmodule

/* fetch_flush_counter.sv */
// Outstanding read and flush counter
// Tracks reads in flight on the bus and, after a restart, how many
// responses are still owed and must be thrown away
module fetch_flush_counter #(
	parameter int FETCH_LIMIT = fetch_pkg::DEFAULT_FETCH_LIMIT
) (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  logic i_restart,
	input  logic i_arvalid,
	input  logic i_arready,
	input  logic i_rvalid,
	output logic o_flushing,
	output logic o_bus_full
);

	import fetch_pkg::*;

	localparam int W = outstanding_bits(FETCH_LIMIT);
	localparam int CW = W + 1;

	logic [W:0] outstanding;
	logic [W:0] next_outstanding;
	logic [W:0] new_flush_count;
	logic [W:0] flush_count;

	// Accepted requests minus responses
	always_comb
	begin
		next_outstanding = outstanding;
		case ({i_arvalid && i_arready, i_rvalid})
		2'b10: next_outstanding = outstanding + 1'b1;
		2'b01: next_outstanding = outstanding - 1'b1;
		default: ;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			outstanding <= '0;
			o_bus_full <= 1'b0;
		end
		else
		begin
			outstanding <= next_outstanding;
			o_bus_full <= (next_outstanding >= (1 << W) - 1);
		end
	end

	// Owed responses, counting a request not yet accepted
	// Response in the restart cycle is dropped by the FIFO clear
	assign new_flush_count = outstanding + CW'(i_arvalid) - CW'(i_rvalid);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			flush_count <= '0;
			o_flushing <= 1'b0;
		end
		else if (i_restart)
		begin
			flush_count <= new_flush_count;
			o_flushing <= (new_flush_count != 0);
		end
		else if (i_rvalid && flush_count != 0)
		begin
			flush_count <= flush_count - 1'b1;
			o_flushing <= (flush_count > 1);
		end
	end

endmodule

/* fetch_word_fifo.sv */
// Fetch word cache
// Synchronous FIFO of returned bus words, each with its error flag
// Head entry is visible before it is read
module fetch_word_fifo #(
	parameter int DATA_WIDTH  = fetch_pkg::DEFAULT_DATA_WIDTH,
	parameter int FETCH_LIMIT = fetch_pkg::DEFAULT_FETCH_LIMIT
) (
	input  logic                  S_AXI_ACLK,
	input  logic                  i_clear,
	input  logic                  i_wr,
	input  logic [DATA_WIDTH-1:0] i_word,
	input  logic                  i_word_err,
	input  logic                  i_rd,
	output logic [DATA_WIDTH-1:0] o_word,
	output logic                  o_word_err,
	output logic                  o_empty
);

	// Depth bits, plus a wrap bit on each pointer
	localparam int LG_DEPTH = $clog2(FETCH_LIMIT);

	logic [DATA_WIDTH:0] mem [FETCH_LIMIT];
	logic [LG_DEPTH:0]   wr_ptr;
	logic [LG_DEPTH:0]   rd_ptr;

	assign o_empty = (wr_ptr == rd_ptr);

	// No full check, the request throttle bounds the fill
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_wr)
			mem[wr_ptr[LG_DEPTH-1:0]] <= {i_word_err, i_word};
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_clear)
			wr_ptr <= '0;
		else if (i_wr)
			wr_ptr <= wr_ptr + 1'b1;
	end

	// Read of an empty FIFO is ignored
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_clear)
			rd_ptr <= '0;
		else if (i_rd && !o_empty)
			rd_ptr <= rd_ptr + 1'b1;
	end

	// Fall-through head
	assign {o_word_err, o_word} = mem[rd_ptr[LG_DEPTH-1:0]];

endmodule

/* fetch_insn_unpack.sv */
// Instruction unpacker
// Splits cached bus words into instructions, hands them to the CPU
// one per handshake and keeps the program counter of each
module fetch_insn_unpack #(
	parameter int ADDR_WIDTH = fetch_pkg::DEFAULT_ADDR_WIDTH,
	parameter int DATA_WIDTH = fetch_pkg::DEFAULT_DATA_WIDTH,
	parameter int INSN_WIDTH = fetch_pkg::DEFAULT_INSN_WIDTH
) (
	input  logic                  S_AXI_ACLK,
	input  logic                  i_restart,
	input  logic                  i_new_pc,
	input  logic [ADDR_WIDTH-1:0] i_pc,
	input  logic                  i_ready,
	input  logic [DATA_WIDTH-1:0] i_word,
	input  logic                  i_word_err,
	input  logic                  i_empty,
	output logic                  o_word_rd,
	output logic                  o_held_words,
	output logic [INSN_WIDTH-1:0] o_insn,
	output logic [ADDR_WIDTH-1:0] o_pc,
	output logic                  o_valid,
	output logic                  o_illegal
);

	localparam int WORD_LSB = $clog2(DATA_WIDTH/8);
	localparam int INSN_LSB = $clog2(INSN_WIDTH/8);
	localparam int INSNS_PER_WORD = DATA_WIDTH / INSN_WIDTH;
	localparam int FILL_W = $clog2(INSNS_PER_WORD) + 1;

	// Instructions of the held word not yet taken
	logic [FILL_W-1:0]     out_fill;
	logic [DATA_WIDTH-1:0] out_data;
	logic [WORD_LSB-1:0]   skip;
	logic                  accept;

	// Start slot of the first word after a redirect
	assign skip = o_pc[WORD_LSB-1:0] >> INSN_LSB;

	// An illegal instruction is never consumed
	assign accept = o_valid && i_ready && !o_illegal;

	// Idle, or the last instruction leaves this cycle
	assign o_word_rd = !o_illegal && (!o_valid || (i_ready && out_fill <= 1));

	assign o_held_words = o_valid && (!i_ready || o_illegal || out_fill > 1);

	assign o_insn = out_data[INSN_WIDTH-1:0];

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_restart)
		begin
			o_valid <= 1'b0;
			o_illegal <= 1'b0;
			out_fill <= '0;
		end
		else if (o_word_rd)
		begin
			o_valid <= !i_empty;
			if (i_empty)
				out_fill <= '0;
			else if (o_valid)
				out_fill <= FILL_W'(INSNS_PER_WORD);
			else
				out_fill <= FILL_W'(INSNS_PER_WORD) - FILL_W'(skip);
			// Error sticks until the next restart
			if (!i_empty)
				o_illegal <= i_word_err;
		end
		else if (accept)
			out_fill <= out_fill - 1'b1;
	end

	// Lowest instruction always at the bottom
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_word_rd)
		begin
			if (o_valid)
				out_data <= i_word;
			else
				out_data <= i_word >> (INSN_WIDTH * skip);
		end
		else if (accept)
			out_data <= out_data >> INSN_WIDTH;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_new_pc)
			o_pc <= i_pc;
		else if (accept)
			o_pc <= ((o_pc >> INSN_LSB) + 1'b1) << INSN_LSB;
	end

endmodule

/* axil_insn_fetch.sv */
// AXI-lite instruction fetch unit
// Streams read requests from a CPU-set program counter, caches the
// returned words and feeds instructions to the CPU one at a time
module axil_insn_fetch #(
	parameter int ADDR_WIDTH  = fetch_pkg::DEFAULT_ADDR_WIDTH,
	parameter int DATA_WIDTH  = fetch_pkg::DEFAULT_DATA_WIDTH,
	parameter int INSN_WIDTH  = fetch_pkg::DEFAULT_INSN_WIDTH,
	parameter int FETCH_LIMIT = fetch_pkg::DEFAULT_FETCH_LIMIT
) (
	input  logic                  S_AXI_ACLK,
	input  logic                  S_AXI_ARESETN,
	// CPU side
	input  logic                  i_cpu_reset,
	input  logic                  i_new_pc,
	input  logic                  i_clear_cache,
	input  logic [ADDR_WIDTH-1:0] i_pc,
	input  logic                  i_ready,
	output logic [INSN_WIDTH-1:0] o_insn,
	output logic [ADDR_WIDTH-1:0] o_pc,
	output logic                  o_valid,
	output logic                  o_illegal,
	// AXI-lite read address channel
	output logic                  o_axi_arvalid,
	input  logic                  i_axi_arready,
	output logic [ADDR_WIDTH-1:0] o_axi_araddr,
	output logic [2:0]            o_axi_arprot,
	// AXI-lite read data channel
	input  logic                  i_axi_rvalid,
	output logic                  o_axi_rready,
	input  logic [DATA_WIDTH-1:0] i_axi_rdata,
	input  logic [1:0]            i_axi_rresp
);

	import fetch_pkg::*;

	logic                  restart;
	logic                  flushing;
	logic                  bus_full;
	logic                  fifo_wr;
	logic                  word_rd;
	logic                  word_taken;
	logic                  held_words;
	logic [DATA_WIDTH-1:0] fifo_word;
	logic                  fifo_err;
	logic                  fifo_empty;

	assign o_axi_arprot = ARPROT_INSN;
	// Responses are never back-pressured
	assign o_axi_rready = 1'b1;

	// Responses owed from before a restart are dropped
	assign fifo_wr = i_axi_rvalid && !flushing;
	assign word_taken = word_rd && !fifo_empty;

	fetch_request_ctrl #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.DATA_WIDTH (DATA_WIDTH),
		.FETCH_LIMIT(FETCH_LIMIT)
	) u_request_ctrl (
		.S_AXI_ACLK     (S_AXI_ACLK),
		.S_AXI_ARESETN  (S_AXI_ARESETN),
		.i_cpu_reset    (i_cpu_reset),
		.i_new_pc       (i_new_pc),
		.i_clear_cache  (i_clear_cache),
		.i_pc           (i_pc),
		.i_arready      (i_axi_arready),
		.i_word_taken   (word_taken),
		.i_held_words   (held_words),
		.i_bus_full     (bus_full),
		.o_arvalid      (o_axi_arvalid),
		.o_araddr       (o_axi_araddr),
		.o_restart      (restart),
		.o_flush_request()
	);

	fetch_flush_counter #(
		.FETCH_LIMIT(FETCH_LIMIT)
	) u_flush_counter (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_restart    (restart),
		.i_arvalid    (o_axi_arvalid),
		.i_arready    (i_axi_arready),
		.i_rvalid     (i_axi_rvalid),
		.o_flushing   (flushing),
		.o_bus_full   (bus_full)
	);

	fetch_word_fifo #(
		.DATA_WIDTH (DATA_WIDTH),
		.FETCH_LIMIT(FETCH_LIMIT)
	) u_word_fifo (
		.S_AXI_ACLK(S_AXI_ACLK),
		.i_clear   (restart),
		.i_wr      (fifo_wr),
		.i_word    (i_axi_rdata),
		.i_word_err(i_axi_rresp[RESP_ERR_BIT]),
		.i_rd      (word_rd),
		.o_word    (fifo_word),
		.o_word_err(fifo_err),
		.o_empty   (fifo_empty)
	);

	fetch_insn_unpack #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.DATA_WIDTH(DATA_WIDTH),
		.INSN_WIDTH(INSN_WIDTH)
	) u_insn_unpack (
		.S_AXI_ACLK  (S_AXI_ACLK),
		.i_restart   (restart),
		.i_new_pc    (i_new_pc),
		.i_pc        (i_pc),
		.i_ready     (i_ready),
		.i_word      (fifo_word),
		.i_word_err  (fifo_err),
		.i_empty     (fifo_empty),
		.o_word_rd   (word_rd),
		.o_held_words(held_words),
		.o_insn      (o_insn),
		.o_pc        (o_pc),
		.o_valid     (o_valid),
		.o_illegal   (o_illegal)
	);

endmodule

/* tb_axil_insn_fetch.sv */
// Testbench for the AXI-lite instruction fetch unit
// LFSR-driven bus stalls, response delays and CPU gaps, with every
// accepted instruction checked against the memory rule and a pc predictor
module tb_axil_insn_fetch;

	localparam int CLK_PERIOD = 8;
	// Instructions over all tests for the watchdog
	localparam int TEST_INSNS = 200 + 100 + 150 + 6 * 20 + 8 + 40;

	logic        S_AXI_ACLK = 1'b0;
	logic        S_AXI_ARESETN;
	logic        i_cpu_reset;
	logic        i_new_pc;
	logic        i_clear_cache;
	logic [31:0] i_pc;
	logic        i_ready;
	logic [31:0] o_insn;
	logic [31:0] o_pc;
	logic        o_valid;
	logic        o_illegal;
	logic        o_axi_arvalid;
	logic        i_axi_arready;
	logic [31:0] o_axi_araddr;
	logic [2:0]  o_axi_arprot;
	logic        i_axi_rvalid;
	logic        o_axi_rready;
	logic [63:0] i_axi_rdata;
	logic [1:0]  i_axi_rresp;

	// Random source and bus model
	logic [15:0] lfsr_state = 16'd23721;
	logic [31:0] rsp_addr [$];
	int          rsp_wait [$];
	logic        force_stall = 1'b0;
	logic        ar_stall_last = 1'b0;
	logic [31:0] ar_addr_last = '0;

	// CPU requests for the next cycle
	int          reset_count = 2;
	logic        want_new_pc = 1'b0;
	logic        want_clear = 1'b0;
	logic        stall_redirect = 1'b0;
	logic [31:0] want_pc = '0;
	logic        random_ready = 1'b0;

	// Predictor and bookkeeping
	logic        restart_last = 1'b0;
	logic        hold_last = 1'b0;
	logic [31:0] hold_pc;
	logic [31:0] hold_insn;
	logic [31:0] exp_pc = '0;
	logic        saw_illegal = 1'b0;
	int          accepted = 0;
	int          errors = 0;
	int          test_errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;

	axil_insn_fetch dut_i (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_cpu_reset  (i_cpu_reset),
		.i_new_pc     (i_new_pc),
		.i_clear_cache(i_clear_cache),
		.i_pc         (i_pc),
		.i_ready      (i_ready),
		.o_insn       (o_insn),
		.o_pc         (o_pc),
		.o_valid      (o_valid),
		.o_illegal    (o_illegal),
		.o_axi_arvalid(o_axi_arvalid),
		.i_axi_arready(i_axi_arready),
		.o_axi_araddr (o_axi_araddr),
		.o_axi_arprot (o_axi_arprot),
		.i_axi_rvalid (i_axi_rvalid),
		.o_axi_rready (o_axi_rready),
		.i_axi_rdata  (i_axi_rdata),
		.i_axi_rresp  (i_axi_rresp)
	);

	always #(CLK_PERIOD / 2) S_AXI_ACLK = ~S_AXI_ACLK;

	////////////////////////////////////////////////////////////
	// Random bits and memory rule
	////////////////////////////////////////////////////////////

	// Galois LFSR on x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
	function automatic int rand_bits(input int n);
		int r;
		int i;
		r = 0;
		for (i = 0; i < n; i++)
		begin
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 16'hb400;
			else
				lfsr_state = lfsr_state >> 1;
			r = (r << 1) | lfsr_state[0];
		end
		return r;
	endfunction

	function automatic logic [31:0] insn_at(input logic [31:0] addr);
		return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
	endfunction

	// Two instructions per bus word with the lower address in the low half
	function automatic logic [63:0] word_at(input logic [31:0] addr);
		logic [31:0] base;
		base = {addr[31:3], 3'b000};
		return {insn_at(base + 32'd4), insn_at(base)};
	endfunction

	function automatic logic in_err_range(input logic [31:0] addr);
		return addr >= 32'h0000_8000 && addr <= 32'h0000_80ff;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp)
		else
		begin
			$display("CHECK FAILED %s: expected %h, got %h", name, exp, got);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// One clock cycle of bus model, CPU and predictor
	////////////////////////////////////////////////////////////

	task automatic tick();
		logic rdy;
		@(negedge S_AXI_ACLK);
		if (reset_count != 0)
			reset_count--;
		S_AXI_ARESETN = (reset_count == 0);
		// Output dropped after a restart
		if (restart_last)
		begin
			check_value("o_valid", o_valid, 1'b0);
			check_value("o_illegal", o_illegal, 1'b0);
		end
		// Stalled output must hold
		if (hold_last)
		begin
			check_value("o_valid", o_valid, 1'b1);
			check_value("o_pc", o_pc, hold_pc);
			check_value("o_insn", o_insn, hold_insn);
		end
		// Stalled read request keeps its valid and address
		if (ar_stall_last && !restart_last)
			check_value("o_axi_arvalid", o_axi_arvalid, 1'b1);
		if (ar_stall_last && o_axi_arvalid)
			check_value("o_axi_araddr", o_axi_araddr, ar_addr_last);
		// Unprivileged secure instruction access, responses never stalled
		if (o_axi_arvalid)
			check_value("o_axi_arprot", o_axi_arprot, 3'b100);
		check_value("o_axi_rready", o_axi_rready, 1'b1);
		// Response channel with RREADY always high
		if (rsp_addr.size() != 0 && rsp_wait[0] == 0)
		begin
			i_axi_rvalid = 1'b1;
			i_axi_rdata = word_at(rsp_addr[0]);
			i_axi_rresp = in_err_range(rsp_addr[0]) ? 2'b10 : 2'b00;
			void'(rsp_addr.pop_front());
			void'(rsp_wait.pop_front());
		end
		else
		begin
			i_axi_rvalid = 1'b0;
			if (rsp_wait.size() != 0)
				rsp_wait[0]--;
		end
		// Address channel stalls about one cycle in four
		i_axi_arready = force_stall ? 1'b0 : (rand_bits(2) != 0);
		if (o_axi_arvalid && i_axi_arready)
		begin
			rsp_addr.push_back(o_axi_araddr);
			rsp_wait.push_back(rand_bits(2));
		end
		ar_stall_last = o_axi_arvalid && !i_axi_arready;
		ar_addr_last = o_axi_araddr;
		// Redirect only against a request held by the stall
		if (stall_redirect && o_axi_arvalid)
		begin
			want_new_pc = 1'b1;
			stall_redirect = 1'b0;
		end
		restart_last = want_new_pc || want_clear;
		i_new_pc = want_new_pc;
		i_clear_cache = want_clear;
		i_pc = want_pc;
		if (want_new_pc)
			exp_pc = want_pc;
		want_new_pc = 1'b0;
		want_clear = 1'b0;
		rdy = !restart_last && (!random_ready || rand_bits(2) != 0);
		i_ready = rdy;
		hold_last = o_valid && !rdy && !restart_last;
		hold_pc = o_pc;
		hold_insn = o_insn;
		// Handshake at the coming edge
		if (o_valid && !restart_last)
		begin
			if (o_illegal)
			begin
				saw_illegal = 1'b1;
				check_value("o_pc", o_pc, exp_pc);
				check_value("o_illegal", o_illegal, in_err_range(exp_pc));
			end
			else if (rdy)
			begin
				check_value("o_pc", o_pc, exp_pc);
				check_value("o_insn", o_insn, insn_at(exp_pc));
				check_value("o_illegal", o_illegal, in_err_range(exp_pc));
				exp_pc = exp_pc + 32'd4;
				accepted++;
			end
		end
	endtask

	// Run until n more instructions are accepted
	task automatic collect(input int n);
		int target;
		int cyc;
		target = accepted + n;
		for (cyc = 0; accepted < target && cyc < n * 40; cyc++)
			tick();
		assert (accepted >= target)
		else
		begin
			$display("timeout, only %0d of %0d instructions accepted",
				n - (target - accepted), n);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != test_errors)
			tests_failed++;
		$display("test %0d %s: %s, %0d errors", tests_run, name,
			(errors == test_errors) ? "ok" : "failed", errors - test_errors);
		test_errors = errors;
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	initial
	begin
		int i;
		int n;
		S_AXI_ARESETN = 1'b0;
		i_cpu_reset = 1'b0;
		i_new_pc = 1'b1;
		i_clear_cache = 1'b0;
		i_pc = '0;
		i_ready = 1'b0;
		i_axi_arready = 1'b0;
		i_axi_rvalid = 1'b0;
		i_axi_rdata = '0;
		i_axi_rresp = 2'b00;
		// Start address loaded during reset
		repeat (2)
		begin
			want_new_pc = 1'b1;
			tick();
		end

		want_new_pc = 1'b1;
		want_pc = 32'h0000_1000;
		collect(200);
		end_test("aligned sequential fetch");

		// First instruction is the high half of its word
		want_new_pc = 1'b1;
		want_pc = 32'h0000_2004;
		collect(100);
		end_test("unaligned start");

		random_ready = 1'b1;
		want_new_pc = 1'b1;
		want_pc = 32'h0000_3000;
		collect(150);
		end_test("cpu back-pressure");

		for (i = 0; i < 6; i++)
		begin
			want_pc = 32'h0000_1000 + (rand_bits(12) << 2);
			if (i % 2 == 1)
			begin
				// Hold ARREADY low so the redirect meets a stalled read
				force_stall = 1'b1;
				stall_redirect = 1'b1;
				for (n = 0; stall_redirect && n < 200; n++)
					tick();
				assert (!stall_redirect)
				else
				begin
					$display("redirect never met a stalled read request");
					errors++;
				end
				repeat (3) tick();
				force_stall = 1'b0;
				stall_redirect = 1'b0;
			end
			else
				want_new_pc = 1'b1;
			collect(20);
		end
		end_test("redirect mid-stream");

		// Eight good instructions before the error word at 0x8000
		saw_illegal = 1'b0;
		want_new_pc = 1'b1;
		want_pc = 32'h0000_7fe0;
		for (n = 0; !saw_illegal && n < 1000; n++)
			tick();
		assert (saw_illegal)
		else
		begin
			$display("no illegal instruction reported for the error range");
			errors++;
		end
		want_clear = 1'b1;
		tick();
		want_new_pc = 1'b1;
		want_pc = 32'h0000_0400;
		collect(40);
		end_test("bus error and cache clear");

		$display("tests run %0d, failed %0d, check errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(TEST_INSNS * 50 * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the run did not complete",
			TEST_INSNS * 50);
		$display("TEST FAIL");
		$finish;
	end

endmodule

/* vlog.f */
fetch_pkg.sv
fetch_request_ctrl.sv
fetch_flush_counter.sv
fetch_word_fifo.sv
fetch_insn_unpack.sv
axil_insn_fetch.sv
tb_axil_insn_fetch.sv

/* Bender.yml */
package:
  name: axil_insn_fetch

sources:
  - fetch_pkg.sv
  - fetch_request_ctrl.sv
  - fetch_flush_counter.sv
  - fetch_word_fifo.sv
  - fetch_insn_unpack.sv
  - axil_insn_fetch.sv
  - target: test
    files:
      - tb_axil_insn_fetch.sv
